// ==== build.f ====
router_pkg.sv
router_two_fifo.sv
router_input_port.sv
router_rr_arbiter.sv
mesh_router_buffered.sv
router_reflector.sv
router_tile.sv
tb_router_tile.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_router_tile
RTL_TOP   ?= router_tile
FILELIST  ?= build.f

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '\*\*\* PASSED \*\*\*'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== tb_router_tile.sv ====
`timescale 1ns/1ps

module tb_router_tile;

  localparam int max_rows_lp = 128;
  localparam int dirs_lp     = router_pkg::dirs_lp;

  logic              clk;
  logic              arst_n;
  logic [3:0]        my_x;
  logic [3:0]        my_y;
  router_pkg::link_s to_dut   [dirs_lp];
  router_pkg::link_s from_dut [dirs_lp];

  // One flit per table row. Its payload carries the row number.
  int                r_in      [max_rows_lp];
  int                r_last_in [max_rows_lp]; // Router input of the final hop.
  int                r_out     [max_rows_lp];
  int                r_lat     [max_rows_lp]; // Zero when timing is not checked.
  int                r_batch   [max_rows_lp];
  bit                r_alt     [max_rows_lp];
  bit                r_rand    [max_rows_lp];
  router_pkg::flit_u r_flit    [max_rows_lp];
  router_pkg::flit_u r_exp     [max_rows_lp];
  int                sent_cyc  [max_rows_lp];
  int                n_rows;
  int                n_batches;

  int in_q  [dirs_lp][$];
  int exp_q [dirs_lp][dirs_lp][$]; // Per router input and output in send order.
  int last_alt_in [dirs_lp];
  int cyc;
  int outstanding;
  bit rand_ready;
  bit built;

  router_tile router_tile_i (
    .clk_i   (clk),
    .arst_n_i(arst_n),
    .link_w_i(to_dut[router_pkg::W]),
    .link_w_o(from_dut[router_pkg::W]),
    .link_e_i(to_dut[router_pkg::E]),
    .link_e_o(from_dut[router_pkg::E]),
    .link_n_i(to_dut[router_pkg::N]),
    .link_n_o(from_dut[router_pkg::N]),
    .link_s_i(to_dut[router_pkg::S]),
    .link_s_o(from_dut[router_pkg::S]),
    .my_x_i  (my_x),
    .my_y_i  (my_y)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // X first, then Y.
  function automatic int xy_dir(logic [3:0] x, logic [3:0] y);
    if (x < my_x) return int'(router_pkg::W);
    if (x > my_x) return int'(router_pkg::E);
    if (y < my_y) return int'(router_pkg::N);
    if (y > my_y) return int'(router_pkg::S);
    return int'(router_pkg::P);
  endfunction

  task automatic fail(string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      fail($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic add_row(int in_dir, logic [3:0] dx, logic [3:0] dy, logic [3:0] sx,
                         logic [3:0] sy, bit timed, bit alt, bit rnd);
    router_pkg::flit_u f;
    router_pkg::flit_u e;
    f.hdr = '{payload: 16'(n_rows), src_y: sy, src_x: sx, dst_y: dy, dst_x: dx};
    e = f;
    r_out[n_rows]     = xy_dir(dx, dy);
    r_lat[n_rows]     = 1;
    r_last_in[n_rows] = in_dir;
    if (r_out[n_rows] == int'(router_pkg::P)) begin
      e.hdr = '{payload: 16'(n_rows), src_y: dy, src_x: dx, dst_y: sy, dst_x: sx};
      r_out[n_rows]     = xy_dir(sx, sy);
      r_lat[n_rows]     = 4; // Reflector loop.
      r_last_in[n_rows] = int'(router_pkg::P);
    end
    if (!timed) r_lat[n_rows] = 0;
    r_in[n_rows]    = in_dir;
    r_flit[n_rows]  = f;
    r_exp[n_rows]   = e;
    r_alt[n_rows]   = alt;
    r_rand[n_rows]  = rnd;
    r_batch[n_rows] = n_batches;
    n_rows++;
  endtask

  task automatic add_directed(int in_dir, logic [3:0] dx, logic [3:0] dy, logic [3:0] sx,
                              logic [3:0] sy);
    add_row(in_dir, dx, dy, sx, sy, 1, 0, 0);
    n_batches++;
  endtask

  task automatic build_table();
    int in_dir;
    logic [3:0] sx;
    logic [3:0] sy;
    // One directed row per batch. S rows come last so S is the last N winner.
    add_directed(router_pkg::W, 9, 5, 2, 5);
    add_directed(router_pkg::W, 5, 1, 2, 5);
    add_directed(router_pkg::W, 5, 9, 2, 5);
    add_directed(router_pkg::W, 5, 5, 2, 5);
    add_directed(router_pkg::E, 1, 5, 9, 5);
    add_directed(router_pkg::E, 5, 1, 9, 5);
    add_directed(router_pkg::E, 5, 9, 9, 5);
    add_directed(router_pkg::E, 5, 5, 9, 5);
    add_directed(router_pkg::N, 5, 9, 5, 2);
    add_directed(router_pkg::N, 5, 5, 5, 2);
    add_directed(router_pkg::S, 5, 1, 5, 9);
    add_directed(router_pkg::S, 5, 5, 5, 9);
    for (int k = 0; k < 4; k++) begin
      add_row(router_pkg::W, 5, 1, 2, 5, 0, 1, 0);
      add_row(router_pkg::E, 5, 1, 9, 5, 0, 1, 0);
    end
    n_batches++;
    // Random streams; sources never sit on this tile.
    for (int k = 0; k < 48; k++) begin
      in_dir = 1 + k % 4;
      case (in_dir)
        1: begin
          sx = 4'($urandom % 5);
          sy = 4'($urandom);
        end
        2: begin
          sx = 4'(6 + $urandom % 10);
          sy = 4'($urandom);
        end
        3: begin
          sx = 4'd5;
          sy = 4'($urandom % 5);
        end
        default: begin
          sx = 4'd5;
          sy = 4'(6 + $urandom % 10);
        end
      endcase
      add_row(in_dir, 4'($urandom), 4'($urandom), sx, sy, 0, 0, 1);
    end
    n_batches++;
  endtask

  task automatic collect(int d);
    int id;
    int src;
    int hop;
    id  = int'(from_dut[d].data.hdr.payload);
    if (id >= n_rows) fail("A flit arrived with a payload that no row sent");
    src = r_in[id];
    hop = r_last_in[id];
    check($sformatf("out_port of row %0d", id), d, r_out[id]);
    check($sformatf("link_o[%0d].data", d), from_dut[d].data.raw, r_exp[id].raw);
    if (exp_q[hop][d].size() == 0) fail("A flit arrived twice on the same path");
    check("arrival row", exp_q[hop][d].pop_front(), id);
    if (r_lat[id] != 0) check("latency", cyc - sent_cyc[id], r_lat[id]);
    if (r_alt[id]) begin
      if (last_alt_in[d] >= 0) begin
        check("arbitration source", src, last_alt_in[d] == 1 ? 2 : 1);
      end
      last_alt_in[d] = src;
    end
    outstanding--;
  endtask

  // Drive at the falling edge, then sample settled handshakes.
  task automatic step();
    @(negedge clk);
    cyc++;
    for (int d = 1; d < dirs_lp; d++) begin
      to_dut[d].v             = in_q[d].size() > 0;
      to_dut[d].data          = to_dut[d].v ? r_flit[in_q[d][0]] : '0;
      to_dut[d].ready_and_rev = rand_ready ? 1'($urandom) : 1'b1;
    end
    #2;
    for (int d = 1; d < dirs_lp; d++) begin
      if (to_dut[d].v && from_dut[d].ready_and_rev) begin
        sent_cyc[in_q[d][0]] = cyc;
        void'(in_q[d].pop_front());
      end
      if (from_dut[d].v && to_dut[d].ready_and_rev) collect(d);
    end
  endtask

  initial begin
    wait (built);
    repeat (n_rows * 50) @(posedge clk);
    fail("Timeout: flits were still outstanding when the watchdog expired");
  end

  initial begin
    int left;
    void'($urandom(32'h74e2_dcdf));
    arst_n = 1'b0;
    my_x   = 4'd5;
    my_y   = 4'd5;
    for (int d = 0; d < dirs_lp; d++) begin
      to_dut[d]      = '0;
      last_alt_in[d] = -1;
    end
    cyc         = 0;
    outstanding = 0;
    n_rows      = 0;
    n_batches   = 0;
    rand_ready  = 1'b0;
    build_table();
    built = 1'b1;
    repeat (10) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #2;
    for (int d = 1; d < dirs_lp; d++) begin
      check($sformatf("link_o[%0d].v", d), from_dut[d].v, 0);
      check($sformatf("link_o[%0d].ready_and_rev", d), from_dut[d].ready_and_rev, 1);
    end
    for (int b = 0; b < n_batches; b++) begin
      for (int i = 0; i < n_rows; i++) begin
        if (r_batch[i] == b) begin
          in_q[r_in[i]].push_back(i);
          exp_q[r_last_in[i]][r_out[i]].push_back(i);
          rand_ready = r_rand[i];
          outstanding++;
        end
      end
      while (outstanding > 0) step();
    end
    left = 0;
    for (int i = 0; i < dirs_lp; i++) begin
      left += in_q[i].size();
      for (int o = 0; o < dirs_lp; o++) left += exp_q[i][o].size();
    end
    if (left == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      fail("Some expected flits were never delivered");
    end
  end

endmodule

// ==== router_tile.sv ====
`timescale 1ns/1ps

module router_tile (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  router_pkg::link_s                    link_w_i,
  output router_pkg::link_s                    link_w_o,
  input  router_pkg::link_s                    link_e_i,
  output router_pkg::link_s                    link_e_o,
  input  router_pkg::link_s                    link_n_i,
  output router_pkg::link_s                    link_n_o,
  input  router_pkg::link_s                    link_s_i,
  output router_pkg::link_s                    link_s_o,
  input  logic [router_pkg::cord_width_lp-1:0] my_x_i,
  input  logic [router_pkg::cord_width_lp-1:0] my_y_i
);

  router_pkg::link_s [router_pkg::dirs_lp-1:0] link_li;
  router_pkg::link_s [router_pkg::dirs_lp-1:0] link_lo;

  mesh_router_buffered rtr (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .link_i  (link_li),
    .link_o  (link_lo),
    .my_x_i  (my_x_i),
    .my_y_i  (my_y_i)
  );

  assign link_li[router_pkg::W] = link_w_i;
  assign link_li[router_pkg::E] = link_e_i;
  assign link_li[router_pkg::N] = link_n_i;
  assign link_li[router_pkg::S] = link_s_i;

  assign link_w_o = link_lo[router_pkg::W];
  assign link_e_o = link_lo[router_pkg::E];
  assign link_n_o = link_lo[router_pkg::N];
  assign link_s_o = link_lo[router_pkg::S];

  // Local port loops back through the reflector.
  router_reflector refl (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .link_i  (link_lo[router_pkg::P]),
    .link_o  (link_li[router_pkg::P])
  );

endmodule

// ==== router_reflector.sv ====
`timescale 1ns/1ps

module router_reflector (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  router_pkg::link_s link_i,
  output router_pkg::link_s link_o
);

  router_pkg::flit_u out_data;
  router_pkg::flit_u swap_data;
  router_pkg::flit_u refl_data;
  logic              out_v;
  logic              out_ready;
  logic              inter_ready;
  logic              refl_v;

  router_two_fifo out_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (link_i.data),
    .v_i     (link_i.v),
    .ready_o (out_ready),
    .data_o  (out_data),
    .v_o     (out_v),
    .yumi_i  (out_v & inter_ready)
  );

  // Back toward the sender.
  assign swap_data.hdr = '{
    payload: out_data.hdr.payload,
    src_y:   out_data.hdr.dst_y,
    src_x:   out_data.hdr.dst_x,
    dst_y:   out_data.hdr.src_y,
    dst_x:   out_data.hdr.src_x
  };

  router_two_fifo inter_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (swap_data),
    .v_i     (out_v),
    .ready_o (inter_ready),
    .data_o  (refl_data),
    .v_o     (refl_v),
    .yumi_i  (refl_v & link_i.ready_and_rev) // Router P input took it.
  );

  assign link_o.v             = refl_v;
  assign link_o.data          = refl_data;
  assign link_o.ready_and_rev = out_ready;

endmodule

// ==== mesh_router_buffered.sv ====
`timescale 1ns/1ps

module mesh_router_buffered (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  router_pkg::link_s [router_pkg::dirs_lp-1:0] link_i,
  output router_pkg::link_s [router_pkg::dirs_lp-1:0] link_o,
  input  logic [router_pkg::cord_width_lp-1:0] my_x_i,
  input  logic [router_pkg::cord_width_lp-1:0] my_y_i
);

  router_pkg::flit_u [router_pkg::dirs_lp-1:0]    head;
  router_pkg::flit_u [router_pkg::dirs_lp-1:0]    out_data;
  logic [router_pkg::dirs_lp-1:0]                 head_v;
  logic [router_pkg::dirs_lp-1:0]                 in_ready;
  logic [router_pkg::dirs_lp-1:0]                 deq;
  logic [router_pkg::dirs_lp-1:0][router_pkg::dirs_lp-1:0] req;   // [in][out].
  logic [router_pkg::dirs_lp-1:0][router_pkg::dirs_lp-1:0] req_t; // [out][in].
  logic [router_pkg::dirs_lp-1:0][router_pkg::dirs_lp-1:0] grant; // [out][in].

  for (genvar gi = 0; gi < router_pkg::dirs_lp; gi++) begin : g_in
    router_input_port in_port (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .link_i  (link_i[gi]),
      .ready_o (in_ready[gi]),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i),
      .head_o  (head[gi]),
      .v_o     (head_v[gi]),
      .req_o   (req[gi]),
      .deq_i   (deq[gi])
    );

    assign link_o[gi].ready_and_rev = in_ready[gi];
  end

  always_comb begin
    for (int o = 0; o < router_pkg::dirs_lp; o++) begin
      for (int i = 0; i < router_pkg::dirs_lp; i++) begin
        req_t[o][i] = req[i][o];
      end
    end
  end

  for (genvar go = 0; go < router_pkg::dirs_lp; go++) begin : g_out
    router_rr_arbiter arb (
      .clk_i   (clk_i),
      .arst_n_i(arst_n_i),
      .req_i   (req_t[go]),
      .ready_i (link_i[go].ready_and_rev),
      .grant_o (grant[go])
    );

    assign link_o[go].v    = |(grant[go] & head_v);
    assign link_o[go].data = out_data[go];
  end

  // Crossbar. Grants are one-hot per output.
  always_comb begin
    for (int o = 0; o < router_pkg::dirs_lp; o++) begin
      out_data[o] = '0;
      for (int i = 0; i < router_pkg::dirs_lp; i++) begin
        if (grant[o][i]) out_data[o] = head[i];
      end
    end
  end

  // Pop where the granted output is taking the flit.
  always_comb begin
    deq = '0;
    for (int i = 0; i < router_pkg::dirs_lp; i++) begin
      for (int o = 0; o < router_pkg::dirs_lp; o++) begin
        if (grant[o][i] && link_i[o].ready_and_rev) deq[i] = 1'b1;
      end
    end
  end

endmodule

// ==== router_rr_arbiter.sv ====
`timescale 1ns/1ps

module router_rr_arbiter (
  input  logic                           clk_i,
  input  logic                           arst_n_i,
  input  logic [router_pkg::dirs_lp-1:0] req_i,
  input  logic                           ready_i,
  output logic [router_pkg::dirs_lp-1:0] grant_o
);

  logic [2:0]                     last_r;
  logic [2:0]                     win_idx;
  logic [router_pkg::dirs_lp-1:0] rr_grant;
  logic [router_pkg::dirs_lp-1:0] lock_grant_r;
  logic                           lock_r;

  // Search starts just after the last winner.
  always_comb begin
    rr_grant = '0;
    for (int i = 1; i <= router_pkg::dirs_lp; i++) begin
      if (rr_grant == '0 && req_i[(int'(last_r) + i) % router_pkg::dirs_lp]) begin
        rr_grant[(int'(last_r) + i) % router_pkg::dirs_lp] = 1'b1;
      end
    end
  end

  assign grant_o = lock_r ? lock_grant_r : rr_grant; // Stalled winner keeps the output.

  always_comb begin
    win_idx = '0;
    for (int i = 0; i < router_pkg::dirs_lp; i++) begin
      if (grant_o[i]) win_idx = 3'(i);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      last_r       <= router_pkg::S; // So P wins first.
      lock_r       <= 1'b0;
      lock_grant_r <= '0;
    end else begin
      if (|grant_o & ready_i) last_r <= win_idx;
      lock_r       <= |grant_o & ~ready_i;
      lock_grant_r <= grant_o;
    end
  end

endmodule

// ==== router_input_port.sv ====
`timescale 1ns/1ps

module router_input_port (
  input  logic                                 clk_i,
  input  logic                                 arst_n_i,
  input  router_pkg::link_s                    link_i,
  output logic                                 ready_o,
  input  logic [router_pkg::cord_width_lp-1:0] my_x_i,
  input  logic [router_pkg::cord_width_lp-1:0] my_y_i,
  output router_pkg::flit_u                    head_o,
  output logic                                 v_o,
  output logic [router_pkg::dirs_lp-1:0]       req_o,
  input  logic                                 deq_i
);

  router_pkg::dir_e                   route_dir;
  logic [router_pkg::dirs_lp-1:0]     route_oh;

  router_two_fifo in_fifo (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .data_i  (link_i.data),
    .v_i     (link_i.v),
    .ready_o (ready_o),
    .data_o  (head_o),
    .v_o     (v_o),
    .yumi_i  (deq_i)
  );

  // X first, then Y.
  always_comb begin
    if (head_o.hdr.dst_x < my_x_i) begin
      route_dir = router_pkg::W;
    end else if (head_o.hdr.dst_x > my_x_i) begin
      route_dir = router_pkg::E;
    end else if (head_o.hdr.dst_y < my_y_i) begin
      route_dir = router_pkg::N;
    end else if (head_o.hdr.dst_y > my_y_i) begin
      route_dir = router_pkg::S;
    end else begin
      route_dir = router_pkg::P; // Arrived.
    end
  end

  always_comb begin
    route_oh = '0;
    route_oh[route_dir] = 1'b1;
  end

  assign req_o = v_o ? route_oh : '0;

endmodule

// ==== router_two_fifo.sv ====
`timescale 1ns/1ps

module router_two_fifo (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  router_pkg::flit_u data_i,
  input  logic              v_i,
  output logic              ready_o,
  output router_pkg::flit_u data_o,
  output logic              v_o,
  input  logic              yumi_i
);

  router_pkg::flit_u mem_r [2];
  logic              wr_ptr_r;
  logic              rd_ptr_r;
  logic              full_r;
  logic              empty_r;
  logic              enq;

  assign enq     = v_i & ~full_r;
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= 1'b0;
      rd_ptr_r <= 1'b0;
      full_r   <= 1'b0;
      empty_r  <= 1'b1;
    end else begin
      if (enq) wr_ptr_r <= ~wr_ptr_r;
      if (yumi_i) rd_ptr_r <= ~rd_ptr_r;
      if (enq & ~yumi_i) begin
        empty_r <= 1'b0;
        full_r  <= ~empty_r; // Second entry fills.
      end else if (yumi_i & ~enq) begin
        full_r  <= 1'b0;
        empty_r <= ~full_r; // Last entry leaves.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) mem_r[wr_ptr_r] <= data_i;
  end

endmodule

// ==== router_pkg.sv ====
package router_pkg;

  localparam int flit_width_lp    = 32;
  localparam int cord_width_lp    = 4;
  localparam int payload_width_lp = 16;
  localparam int dirs_lp          = 5;

  // Port order also indexes every port array.
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  typedef struct packed {
    logic [payload_width_lp-1:0] payload;
    logic [cord_width_lp-1:0]    src_y;
    logic [cord_width_lp-1:0]    src_x;
    logic [cord_width_lp-1:0]    dst_y;
    logic [cord_width_lp-1:0]    dst_x;
  } flit_hdr_s;

  typedef union packed {
    logic [flit_width_lp-1:0] raw; // Buffers and crossbar.
    flit_hdr_s                hdr; // Route decode and reflector.
  } flit_u;

  typedef struct packed {
    logic  v;
    logic  ready_and_rev; // Backward ready of the opposite direction.
    flit_u data;
  } link_s;

endpackage
